//--- common/decomp_pkg.sv
package decomp_pkg;

    //------------------------------
    // bus encodings
    //------------------------------
    typedef logic [1:0] htrans_t;
    typedef logic [2:0] hsize_t;
    typedef logic [2:0] hburst_t;

    localparam htrans_t HTRANS_IDLE   = 2'b00;
    localparam htrans_t HTRANS_NONSEQ = 2'b10;
    localparam htrans_t HTRANS_SEQ    = 2'b11;

    localparam hsize_t  HSIZE_WORD    = 3'b010;
    localparam hburst_t HBURST_INCR16 = 3'b111;

    //------------------------------
    // block geometry
    //------------------------------
    localparam int BEATS_PER_BURST    = 16;
    localparam int BLK_BYTES_LOG2     = 6;
    // expanded output is twice the input block
    localparam int OUT_BLK_BYTES_LOG2 = 7;
    localparam int NUM_LANES          = 3;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;
    typedef logic [25:0] blk_cnt_t;
    typedef logic [3:0]  beat_t;
    typedef logic [3:0]  buf_addr_t;
    typedef logic [1:0]  lane_sel_t;

    typedef enum logic [2:0] {
        BLK_IDLE,
        BLK_READ,
        BLK_DECOMP,
        BLK_WRITE_LO,
        BLK_WRITE_HI
    } blk_state_t;

    typedef enum logic [2:0] {
        BUR_IDLE,
        BUR_REQ,
        BUR_FIRST_ADDR,
        BUR_MIDDLE,
        BUR_LAST_DATA
    } burst_state_t;

endpackage

//--- common/burst_if.sv
`timescale 1ns/1ps

interface burst_if;
    import decomp_pkg::*;

    // one-cycle request for a 16-beat access
    logic  start;
    logic  write;
    addr_t base;
    // selects the upper half of the result buffer
    logic  hi_half;
    // pulses with the last data phase
    logic  done;

    modport seq (
        output start,
        output write,
        output base,
        output hi_half,
        input  done
    );

    modport eng (
        input  start,
        input  write,
        input  base,
        input  hi_half,
        output done
    );

endinterface

//--- rtl/block_sequencer.sv
`timescale 1ns/1ps

module block_sequencer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  decomp_pkg::addr_t    src_addr_i,
    input  decomp_pkg::addr_t    dst_addr_i,
    input  decomp_pkg::blk_cnt_t len_i,
    input  logic                 start_i,
    input  logic                 decomp_done_i,
    output logic                 done_o,
    burst_if.seq                 bus
);
    import decomp_pkg::*;

    blk_state_t state;
    blk_cnt_t   blk_cnt;
    blk_cnt_t   blk_cnt_nxt;
    logic       burst_start;
    addr_t      blk_off;
    addr_t      rd_base;
    addr_t      wr_base;

    assign blk_cnt_nxt = blk_cnt + 1'b1;

    //------------------------------
    // address bases
    //------------------------------
    assign blk_off = addr_t'(blk_cnt);
    assign rd_base = src_addr_i + (blk_off << BLK_BYTES_LOG2);
    assign wr_base = dst_addr_i + (blk_off << OUT_BLK_BYTES_LOG2);

    always_comb begin
        case (state)
            BLK_WRITE_LO: bus.base = wr_base;
            // upper half lands one input block size further
            BLK_WRITE_HI: bus.base = wr_base + addr_t'(BEATS_PER_BURST * 4);
            default:      bus.base = rd_base;
        endcase
    end

    assign bus.write   = (state == BLK_WRITE_LO) || (state == BLK_WRITE_HI);
    assign bus.hi_half = (state == BLK_WRITE_HI);
    assign bus.start   = burst_start;

    //------------------------------
    // phase machine
    //------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= BLK_IDLE;
            blk_cnt     <= '0;
            burst_start <= 1'b0;
        end else begin
            burst_start <= 1'b0;
            case (state)
                BLK_IDLE: begin
                    // zero length is ignored
                    if (start_i && (len_i != '0)) begin
                        blk_cnt     <= '0;
                        burst_start <= 1'b1;
                        state       <= BLK_READ;
                    end
                end
                BLK_READ: begin
                    if (bus.done) begin
                        state <= BLK_DECOMP;
                    end
                end
                BLK_DECOMP: begin
                    if (decomp_done_i) begin
                        burst_start <= 1'b1;
                        state       <= BLK_WRITE_LO;
                    end
                end
                BLK_WRITE_LO: begin
                    if (bus.done) begin
                        burst_start <= 1'b1;
                        state       <= BLK_WRITE_HI;
                    end
                end
                BLK_WRITE_HI: begin
                    if (bus.done) begin
                        blk_cnt <= blk_cnt_nxt;
                        if (blk_cnt_nxt == len_i) begin
                            state <= BLK_IDLE;
                        end else begin
                            burst_start <= 1'b1;
                            state       <= BLK_READ;
                        end
                    end
                end
                default: state <= BLK_IDLE;
            endcase
        end
    end

    // low start keeps status reads from racing a new command
    assign done_o = (state == BLK_IDLE) && !start_i;

endmodule

//--- burst_engine/burst_engine.sv
`timescale 1ns/1ps

module burst_engine (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  hgrant_i,
    input  logic                  hready_i,
    input  decomp_pkg::dword_t    decomp_rdata_i,
    output logic                  hbusreq_o,
    output decomp_pkg::addr_t     haddr_o,
    output decomp_pkg::htrans_t   htrans_o,
    output logic                  hwrite_o,
    output decomp_pkg::word_t     hwdata_o,
    output decomp_pkg::buf_addr_t buf_addr_o,
    output logic                  beat_en_o,
    output decomp_pkg::beat_t     beat_o,
    burst_if.eng                  bus
);
    import decomp_pkg::*;

    // address phase k overlaps data phase k-1
    //   REQ         wait for grant
    //   FIRST_ADDR  address 0 only
    //   MIDDLE      address and data together
    //   LAST_DATA   data 15 only

    burst_state_t state;
    beat_t        beat;
    logic         hbusreq;
    addr_t        haddr;
    htrans_t      htrans;
    logic         hwrite;
    word_t        hwdata;
    beat_t        last_addr_beat;
    word_t        wr_half;
    logic         addr_taken;

    // reads count data phases, writes count address phases
    assign last_addr_beat = hwrite ? beat_t'(BEATS_PER_BURST - 1)
                                   : beat_t'(BEATS_PER_BURST - 2);

    // upper half on even beats
    assign wr_half = beat[0] ? decomp_rdata_i[31:0] : decomp_rdata_i[63:32];

    assign addr_taken = hready_i &&
                        ((state == BUR_FIRST_ADDR) || (state == BUR_MIDDLE));

    //------------------------------
    // burst control
    //------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= BUR_IDLE;
            beat    <= '0;
            hbusreq <= 1'b0;
            haddr   <= '0;
            htrans  <= HTRANS_IDLE;
            hwrite  <= 1'b0;
        end else begin
            case (state)
                BUR_IDLE: begin
                    if (bus.start) begin
                        hbusreq <= 1'b1;
                        state   <= BUR_REQ;
                    end
                end
                BUR_REQ: begin
                    if (hgrant_i) begin
                        haddr  <= bus.base;
                        htrans <= HTRANS_NONSEQ;
                        hwrite <= bus.write;
                        beat   <= '0;
                        state  <= BUR_FIRST_ADDR;
                    end
                end
                BUR_FIRST_ADDR: begin
                    if (hready_i) begin
                        haddr  <= haddr + addr_t'(4);
                        htrans <= HTRANS_SEQ;
                        // no data phase yet on a read
                        if (hwrite) begin
                            beat <= beat + 1'b1;
                        end
                        state  <= BUR_MIDDLE;
                    end
                end
                BUR_MIDDLE: begin
                    if (hready_i) begin
                        haddr <= haddr + addr_t'(4);
                        beat  <= beat + 1'b1;
                        // release the bus while address 15 is out
                        if (beat == beat_t'(last_addr_beat - 1'b1)) begin
                            hbusreq <= 1'b0;
                        end
                        if (beat == last_addr_beat) begin
                            htrans <= HTRANS_IDLE;
                            state  <= BUR_LAST_DATA;
                        end
                    end
                end
                BUR_LAST_DATA: begin
                    if (hready_i) begin
                        state <= BUR_IDLE;
                    end
                end
                default: state <= BUR_IDLE;
            endcase
        end
    end

    // write data follows its address phase by one cycle
    always_ff @(posedge clk) begin
        if (hwrite && addr_taken) begin
            hwdata <= wr_half;
        end
    end

    assign bus.done   = (state == BUR_LAST_DATA) && hready_i;

    assign beat_en_o  = !hwrite && hready_i &&
                        ((state == BUR_MIDDLE) || (state == BUR_LAST_DATA));
    assign beat_o     = beat;
    assign buf_addr_o = {bus.hi_half, beat[3:1]};

    assign hbusreq_o  = hbusreq;
    assign haddr_o    = haddr;
    assign htrans_o   = htrans;
    assign hwrite_o   = hwrite;
    assign hwdata_o   = hwdata;

endmodule

//--- burst_engine/lane_dispatch.sv
`timescale 1ns/1ps

module lane_dispatch (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              beat_en_i,
    input  decomp_pkg::beat_t beat_i,
    input  decomp_pkg::word_t hrdata_i,
    output logic              decomp0_wren_o,
    output logic              decomp1_wren_o,
    output logic              decomp2_wren_o,
    output logic              decomp_sop_o,
    output logic              decomp_eop_o,
    output decomp_pkg::word_t decomp_wdata_o
);
    import decomp_pkg::*;

    lane_sel_t              lane;
    lane_sel_t              lane_nxt;
    logic [NUM_LANES-1:0]   wren;
    logic                   sop;
    logic                   eop;
    word_t                  wdata;

    // block header picks the lane, held for the rest of the block
    always_comb begin
        lane_nxt = lane;
        if (beat_en_i && (beat_i == '0)) begin
            if (hrdata_i[31]) begin
                lane_nxt = lane_sel_t'(0);
            end else if (!hrdata_i[30]) begin
                lane_nxt = lane_sel_t'(1);
            end else begin
                lane_nxt = lane_sel_t'(2);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lane <= '0;
            wren <= '0;
            sop  <= 1'b0;
            eop  <= 1'b0;
        end else begin
            lane <= lane_nxt;
            wren <= beat_en_i ? (NUM_LANES'(1) << lane_nxt) : '0;
            sop  <= beat_en_i && (beat_i == '0);
            eop  <= beat_en_i && (beat_i == beat_t'(BEATS_PER_BURST - 1));
        end
    end

    always_ff @(posedge clk) begin
        if (beat_en_i) begin
            wdata <= hrdata_i;
        end
    end

    assign decomp0_wren_o = wren[0];
    assign decomp1_wren_o = wren[1];
    assign decomp2_wren_o = wren[2];
    assign decomp_sop_o   = sop;
    assign decomp_eop_o   = eop;
    assign decomp_wdata_o = wdata;

endmodule

//--- rtl/decomp_mover_top.sv
`timescale 1ns/1ps

module decomp_mover_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  decomp_pkg::addr_t     src_addr_i,
    input  decomp_pkg::addr_t     dst_addr_i,
    input  decomp_pkg::blk_cnt_t  len_i,
    input  logic                  start_i,
    output logic                  done_o,

    output logic                  hbusreq_o,
    input  logic                  hgrant_i,
    output decomp_pkg::addr_t     haddr_o,
    output decomp_pkg::htrans_t   htrans_o,
    output logic                  hwrite_o,
    output decomp_pkg::hsize_t    hsize_o,
    output decomp_pkg::hburst_t   hburst_o,
    output decomp_pkg::word_t     hwdata_o,
    input  logic                  hready_i,
    input  decomp_pkg::word_t     hrdata_i,

    output logic                  decomp0_wren_o,
    output logic                  decomp1_wren_o,
    output logic                  decomp2_wren_o,
    output logic                  decomp_sop_o,
    output logic                  decomp_eop_o,
    output decomp_pkg::word_t     decomp_wdata_o,
    input  logic                  decomp_done_i,

    output decomp_pkg::buf_addr_t buf_addr_o,
    input  decomp_pkg::dword_t    decomp_rdata_i
);
    import decomp_pkg::*;

    logic  beat_en;
    beat_t beat;

    burst_if bus ();

    // fixed word size, fixed 16-beat incrementing
    assign hsize_o  = HSIZE_WORD;
    assign hburst_o = HBURST_INCR16;

    block_sequencer u_seq (
        .clk           (clk),
        .rst_n         (rst_n),
        .src_addr_i    (src_addr_i),
        .dst_addr_i    (dst_addr_i),
        .len_i         (len_i),
        .start_i       (start_i),
        .decomp_done_i (decomp_done_i),
        .done_o        (done_o),
        .bus           (bus.seq)
    );

    burst_engine u_eng (
        .clk            (clk),
        .rst_n          (rst_n),
        .hgrant_i       (hgrant_i),
        .hready_i       (hready_i),
        .decomp_rdata_i (decomp_rdata_i),
        .hbusreq_o      (hbusreq_o),
        .haddr_o        (haddr_o),
        .htrans_o       (htrans_o),
        .hwrite_o       (hwrite_o),
        .hwdata_o       (hwdata_o),
        .buf_addr_o     (buf_addr_o),
        .beat_en_o      (beat_en),
        .beat_o         (beat),
        .bus            (bus.eng)
    );

    lane_dispatch u_lane (
        .clk            (clk),
        .rst_n          (rst_n),
        .beat_en_i      (beat_en),
        .beat_i         (beat),
        .hrdata_i       (hrdata_i),
        .decomp0_wren_o (decomp0_wren_o),
        .decomp1_wren_o (decomp1_wren_o),
        .decomp2_wren_o (decomp2_wren_o),
        .decomp_sop_o   (decomp_sop_o),
        .decomp_eop_o   (decomp_eop_o),
        .decomp_wdata_o (decomp_wdata_o)
    );

endmodule

//--- bench/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);
    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    // released just after the fifth rising edge
    initial begin
        rst_n_o = 1'b0;
        repeat (5) @(posedge clk_o);
        #10 rst_n_o = 1'b1;
    end
endmodule

//--- bench/tb_decomp_mover.sv
`timescale 1ns/1ps

module tb_decomp_mover;
    import decomp_pkg::*;

    localparam int NUM_TESTS   = 4;
    localparam int MAX_BLK     = 4;
    localparam int MEM_WORDS   = 4096;
    localparam int BLK_CYCLES  = 400;
    localparam int TEST_CYCLES = 100;

    logic clk, rst_n, start_i, done_o, hbusreq_o, hgrant_i, hwrite_o, hready_i;
    logic decomp0_wren_o, decomp1_wren_o, decomp2_wren_o, decomp_sop_o, decomp_eop_o;
    logic decomp_done_i;
    addr_t src_addr_i, dst_addr_i, haddr_o;
    blk_cnt_t len_i;
    htrans_t htrans_o;
    hsize_t hsize_o;
    hburst_t hburst_o;
    word_t hwdata_o, hrdata_i, decomp_wdata_o;
    buf_addr_t buf_addr_o;
    dword_t decomp_rdata_i;

    // stimulus table, one row per command
    addr_t     tbl_src  [NUM_TESTS];
    addr_t     tbl_dst  [NUM_TESTS];
    blk_cnt_t  tbl_len  [NUM_TESTS];
    word_t     tbl_hdr  [NUM_TESTS][MAX_BLK];
    lane_sel_t tbl_lane [NUM_TESTS][MAX_BLK];

    // bus slave and decoder model state
    word_t       mem [MEM_WORDS];
    word_t       wmem [addr_t];
    logic [31:0] lfsr = 32'h592e_1c1c;
    logic        dp_valid = 1'b0;
    logic        dp_write = 1'b0;
    addr_t       dp_addr = '0;
    int          gnt_wait = 0;
    int          dd_cnt = 0;
    int          buf_blk = 0;
    int          eop_total = 0;
    int          wr_total = 0;
    int          req_total = 0;
    int          mon_err = 0;
    int          err_cnt = 0;
    int          check_cnt = 0;
    addr_t       acc_addr [$];
    htrans_t     acc_trans [$];
    logic        acc_write [$];
    word_t       rd_data [$];
    lane_sel_t   rd_lane [$];
    logic        rd_sop [$];
    logic        rd_eop [$];

    tb_clk_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

    decomp_mover_top dut (.*);

    // Galois LFSR, one step per bit taken
    function automatic int rand_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            r = (r << 1) | int'(lfsr[0]);
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic int mem_idx(input addr_t a);
        return int'(a[13:2]);
    endfunction

    function automatic word_t fill_word(input addr_t a);
        return (a * 32'h9e37_79b9) ^ 32'h1357_2468;
    endfunction

    // result buffer contents per block
    function automatic dword_t buf_word(input int blk, input buf_addr_t a);
        logic [7:0] b;
        b = blk[7:0];
        return {8'hc0, b, 12'h0de, a, 8'h3a, b, 12'hf00, a};
    endfunction

    // beat k of the 32 write beats, upper half first
    function automatic word_t exp_write(input int blk, input int k);
        dword_t w;
        w = buf_word(blk, buf_addr_t'(k >> 1));
        return (k % 2 == 0) ? w[63:32] : w[31:0];
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        check_cnt++;
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got %h, expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_lane(input string name, input lane_sel_t got, input lane_sel_t exp);
        check_cnt++;
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_trans(input string name, input htrans_t got, input htrans_t exp);
        check_cnt++;
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got %b, expected %b", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_size(input string name, input hsize_t got, input hsize_t exp);
        check_cnt++;
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got %b, expected %b", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_burst(input string name, input hburst_t got, input hburst_t exp);
        check_cnt++;
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got %b, expected %b", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        check_cnt++;
        if (got != exp) begin
            $display("FAIL t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic set_row(input int idx, input addr_t src, input addr_t dst,
                           input blk_cnt_t len, input word_t h0, input word_t h1,
                           input word_t h2, input word_t h3, input lane_sel_t l0,
                           input lane_sel_t l1, input lane_sel_t l2, input lane_sel_t l3);
        tbl_src[idx] = src;
        tbl_dst[idx] = dst;
        tbl_len[idx] = len;
        tbl_hdr[idx] = '{h0, h1, h2, h3};
        tbl_lane[idx] = '{l0, l1, l2, l3};
    endtask

    // ------------------------------
    // bus slave and decoder models
    // ------------------------------
    task automatic sample_bus();
        logic [2:0] stb;
        stb = {decomp2_wren_o, decomp1_wren_o, decomp0_wren_o};
        if (!rst_n) begin
            dp_valid = 1'b0;
            return;
        end
        if (hbusreq_o) begin
            req_total++;
        end
        if (hready_i) begin
            if (dp_valid && dp_write) begin
                wmem[dp_addr] = hwdata_o;
                wr_total++;
            end
            dp_valid = (htrans_o == HTRANS_NONSEQ) || (htrans_o == HTRANS_SEQ);
            if (dp_valid) begin
                dp_addr  = haddr_o;
                dp_write = hwrite_o;
                acc_addr.push_back(haddr_o);
                acc_trans.push_back(htrans_o);
                acc_write.push_back(hwrite_o);
                // 4-byte size and 16-beat incrementing burst on every transfer
                check_size("hsize_o", hsize_o, 3'b010);
                check_burst("hburst_o", hburst_o, 3'b111);
            end
        end
        if (stb != 3'b000) begin
            if ($countones(stb) != 1) begin
                $display("error at %0t: more than one decoder lane strobed", $time);
                mon_err++;
            end
            rd_lane.push_back(stb[0] ? 2'd0 : (stb[1] ? 2'd1 : 2'd2));
            rd_data.push_back(decomp_wdata_o);
            rd_sop.push_back(decomp_sop_o);
            rd_eop.push_back(decomp_eop_o);
        end else if (decomp_sop_o || decomp_eop_o) begin
            $display("error at %0t: packet flag without a lane strobe", $time);
            mon_err++;
        end
        if (decomp_eop_o) begin
            dd_cnt  = 1 + rand_bits(3);
            buf_blk = eop_total;
            eop_total++;
        end
    endtask

    task automatic drive_models();
        if (!hbusreq_o) begin
            hgrant_i = 1'b0;
            gnt_wait = rand_bits(2);
        end else if (!hgrant_i) begin
            if (gnt_wait == 0) begin
                hgrant_i = 1'b1;
            end else begin
                gnt_wait--;
            end
        end
        // roughly one wait state in four
        hready_i = (rand_bits(2) != 0);
        hrdata_i = (dp_valid && !dp_write) ? mem[mem_idx(dp_addr)] : 32'hdead_beef;
        decomp_done_i = (dd_cnt == 1);
        if (dd_cnt > 0) begin
            dd_cnt--;
        end
        decomp_rdata_i = buf_word(buf_blk, buf_addr_o);
    endtask

    initial begin
        hgrant_i       = 1'b0;
        hready_i       = 1'b1;
        hrdata_i       = '0;
        decomp_done_i  = 1'b0;
        decomp_rdata_i = '0;
        forever begin
            @(negedge clk);
            sample_bus();
            @(posedge clk);
            #10;
            drive_models();
        end
    end

    task automatic run_watchdog(input int cycles);
        repeat (cycles) @(posedge clk);
        $display("watchdog: run exceeded %0d cycles", cycles);
        $display("Regression failed");
        $finish;
    endtask

    // ------------------------------
    // one command and its checks
    // ------------------------------
    task automatic run_test(input int t);
        int len, errs0, acc0, rd0, wr0, req0, blk0, cycles, e;
        addr_t a;
        len = int'(tbl_len[t]);
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_word(addr_t'(i) << 2);
        end
        for (int b = 0; b < len; b++) begin
            mem[mem_idx(tbl_src[t] + addr_t'(b * 64))] = tbl_hdr[t][b];
        end
        errs0 = err_cnt + mon_err;
        acc0 = acc_addr.size();
        rd0 = rd_data.size();
        wr0 = wr_total;
        req0 = req_total;
        blk0 = eop_total;
        @(posedge clk);
        #10;
        src_addr_i = tbl_src[t];
        dst_addr_i = tbl_dst[t];
        len_i = tbl_len[t];
        start_i = 1'b1;
        @(posedge clk);
        #10;
        start_i = 1'b0;
        cycles = 0;
        @(negedge clk);
        while (!done_o && cycles < len * BLK_CYCLES + TEST_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!done_o) begin
            $display("test %0d: done_o never returned high", t);
            $display("Regression failed");
            $finish;
        end
        if (len == 0) begin
            repeat (20) @(negedge clk);
            check_count("hbusreq cycles", req_total - req0, 0);
            check_count("done_o", int'(done_o), 1);
        end
        check_count("address phases", acc_addr.size() - acc0, 48 * len);
        if (acc_addr.size() - acc0 == 48 * len) begin
            for (int b = 0; b < len; b++) begin
                for (int k = 0; k < 3; k++) begin
                    for (int i = 0; i < 16; i++) begin
                        e = acc0 + (b * 3 + k) * 16 + i;
                        if (k == 0) begin
                            a = tbl_src[t] + addr_t'(b * 64 + i * 4);
                        end else begin
                            a = tbl_dst[t] + addr_t'(b * 128 + (k - 1) * 64 + i * 4);
                        end
                        check_word("haddr", acc_addr[e], a);
                        check_trans("htrans", acc_trans[e],
                                    (i == 0) ? HTRANS_NONSEQ : HTRANS_SEQ);
                        check_count("hwrite", int'(acc_write[e]), (k == 0) ? 0 : 1);
                    end
                end
            end
        end
        check_count("lane strobes", rd_data.size() - rd0, 16 * len);
        if (rd_data.size() - rd0 == 16 * len) begin
            for (int b = 0; b < len; b++) begin
                for (int i = 0; i < 16; i++) begin
                    e = rd0 + b * 16 + i;
                    a = tbl_src[t] + addr_t'(b * 64 + i * 4);
                    check_lane("lane", rd_lane[e], tbl_lane[t][b]);
                    check_word("decomp_wdata", rd_data[e], mem[mem_idx(a)]);
                    check_count("sop", int'(rd_sop[e]), (i == 0) ? 1 : 0);
                    check_count("eop", int'(rd_eop[e]), (i == 15) ? 1 : 0);
                end
            end
        end
        check_count("write beats", wr_total - wr0, 32 * len);
        for (int b = 0; b < len; b++) begin
            for (int k = 0; k < 32; k++) begin
                a = tbl_dst[t] + addr_t'(b * 128 + k * 4);
                if (!wmem.exists(a)) begin
                    $display("error at %0t: no write seen at address %h", $time, a);
                    err_cnt++;
                end else begin
                    check_word("write data", wmem[a], exp_write(blk0 + b, k));
                end
            end
        end
        $display("test %0d: %0d blocks, %0d errors", t, len, err_cnt + mon_err - errs0);
    endtask

    initial begin
        int total_blk;
        int total_err;
        start_i = 1'b0;
        src_addr_i = '0;
        dst_addr_i = '0;
        len_i = '0;
        // lane from bit 31 set, else bit 30 clear, else lane 2
        set_row(0, 32'h0000_0100, 32'h0000_1000, 26'd1,
                32'h8000_0000, 32'h0, 32'h0, 32'h0, 2'd0, 2'd0, 2'd0, 2'd0);
        set_row(1, 32'h0000_0200, 32'h0000_1400, 26'd3,
                32'h1234_5678, 32'h4000_0001, 32'hc000_0000, 32'h0, 2'd1, 2'd2, 2'd0, 2'd0);
        set_row(2, 32'h0000_0280, 32'h0000_1600, 26'd0,
                32'h0, 32'h0, 32'h0, 32'h0, 2'd0, 2'd0, 2'd0, 2'd0);
        set_row(3, 32'h0000_0340, 32'h0000_1800, 26'd4,
                32'h7fff_ffff, 32'h3fff_ffff, 32'hffff_ffff, 32'h5555_5555,
                2'd2, 2'd1, 2'd0, 2'd2);
        total_blk = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            total_blk += int'(tbl_len[t]);
        end
        fork
            run_watchdog(total_blk * BLK_CYCLES + NUM_TESTS * TEST_CYCLES + 50);
        join_none
        @(posedge rst_n);
        @(negedge clk);
        check_count("done_o after reset", int'(done_o), 1);
        check_count("hbusreq_o after reset", int'(hbusreq_o), 0);
        check_trans("htrans_o after reset", htrans_o, HTRANS_IDLE);
        check_count("hwrite_o after reset", int'(hwrite_o), 0);
        check_count("lane strobes after reset",
                    int'({decomp2_wren_o, decomp1_wren_o, decomp0_wren_o}), 0);
        check_count("packet flags after reset", int'({decomp_sop_o, decomp_eop_o}), 0);
        $display("test reset: %0d errors", err_cnt);
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        total_err = err_cnt + mon_err;
        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS + 1, check_cnt, total_err);
        if (total_err == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- sources.f
common/decomp_pkg.sv
common/burst_if.sv
rtl/block_sequencer.sv
burst_engine/burst_engine.sv
burst_engine/lane_dispatch.sv
rtl/decomp_mover_top.sv
bench/tb_clk_gen.sv
bench/tb_decomp_mover.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary -Wno-fatal --top-module tb_decomp_mover -f sources.f -o tb_decomp_mover
	out=$$(./obj_dir/tb_decomp_mover); echo "$$out"; echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir
